// ==== divsqrt_pkg.sv ====
package divsqrt_pkg;

  // ##########################################################################
  // Widths
  // ##########################################################################

  // Operand and result width
  localparam int DATA_W = 32;

  // Instruction tag
  localparam int ID_W = 3;

  // Root bits produced, one per iteration
  localparam int SQRT_STEPS = DATA_W / 2;

  // ##########################################################################
  // Latencies from the accepting edge to done
  // ##########################################################################

  // Load cycle, one step per quotient bit, result cycle
  localparam int DIV_LATENCY = DATA_W + 2;

  // Load cycle, one step per root bit, result cycle
  localparam int SQRT_LATENCY = SQRT_STEPS + 2;

  // ##########################################################################
  // Operation select
  // ##########################################################################

  // Encoding 2'b11 is unused and goes to the square-root unit
  typedef enum logic [1:0] {
    OP_DIV  = 2'b00,
    OP_REM  = 2'b01,
    OP_SQRT = 2'b10
  } op_t;

endpackage

// ==== int_div.sv ====
`timescale 1ns/100ps

module int_div (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           new_request,
  input  logic [divsqrt_pkg::ID_W-1:0]   id,
  input  divsqrt_pkg::op_t               op,
  input  logic [divsqrt_pkg::DATA_W-1:0] rs1,
  input  logic [divsqrt_pkg::DATA_W-1:0] rs2,
  input  logic                           ack,
  output logic                           ready,
  output logic                           done,
  output logic [divsqrt_pkg::ID_W-1:0]   done_id,
  output logic [divsqrt_pkg::DATA_W-1:0] result,
  output logic                           dz
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOAD,
    S_STEP,
    S_RESULT,
    S_DONE
  } state_t;

  state_t state;
  logic [$clog2(divsqrt_pkg::DATA_W)-1:0] step;

  logic [divsqrt_pkg::DATA_W-1:0] dividend;
  logic [divsqrt_pkg::DATA_W-1:0] divisor;
  logic [divsqrt_pkg::DATA_W-1:0] quo;
  logic [divsqrt_pkg::DATA_W-1:0] rem;
  logic                           rem_sel;

  logic [divsqrt_pkg::DATA_W:0]   shifted;
  logic [divsqrt_pkg::DATA_W+1:0] diff;
  logic                           diff_neg;

  // ##########################################################################
  // Control FSM
  // ##########################################################################

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_IDLE;
      step  <= '0;
    end else begin
      case (state)
        S_IDLE: if (new_request) state <= S_LOAD;
        S_LOAD: begin
          state <= S_STEP;
          step  <= '0;
        end
        S_STEP: begin
          step <= step + 1'b1;
          if (step == divsqrt_pkg::DATA_W - 1)
            state <= S_RESULT;
        end
        S_RESULT: state <= S_DONE;
        S_DONE: if (ack) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  assign ready = (state == S_IDLE);
  assign done  = (state == S_DONE);

  // ##########################################################################
  // Restoring shift-subtract datapath
  // ##########################################################################

  // Next dividend bit shifts from the quotient register into the remainder
  assign shifted  = {rem, quo[divsqrt_pkg::DATA_W-1]};
  assign diff     = {1'b0, shifted} - {2'b00, divisor};
  assign diff_neg = diff[divsqrt_pkg::DATA_W+1];

  always_ff @(posedge clk) begin
    case (state)
      S_IDLE: begin
        if (new_request) begin
          dividend <= rs1;
          divisor  <= rs2;
          done_id  <= id;
          rem_sel  <= (op == divsqrt_pkg::OP_REM);
        end
      end
      S_LOAD: begin
        quo <= dividend;
        rem <= '0;
        // Zero divisor never restores: quotient all ones, remainder the dividend
        dz  <= (divisor == '0);
      end
      S_STEP: begin
        quo <= {quo[divsqrt_pkg::DATA_W-2:0], ~diff_neg};
        if (diff_neg)
          rem <= shifted[divsqrt_pkg::DATA_W-1:0];
        else
          rem <= diff[divsqrt_pkg::DATA_W-1:0];
      end
      S_RESULT: result <= rem_sel ? rem : quo;
      default: ;
    endcase
  end

endmodule

// ==== int_sqrt.sv ====
`timescale 1ns/100ps

module int_sqrt (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           new_request,
  input  logic [divsqrt_pkg::ID_W-1:0]   id,
  input  logic [divsqrt_pkg::DATA_W-1:0] rs1,
  input  logic                           ack,
  output logic                           ready,
  output logic                           done,
  output logic [divsqrt_pkg::ID_W-1:0]   done_id,
  output logic [divsqrt_pkg::DATA_W-1:0] result
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOAD,
    S_STEP,
    S_RESULT,
    S_DONE
  } state_t;

  state_t state;
  logic [$clog2(divsqrt_pkg::SQRT_STEPS)-1:0] step;

  logic [divsqrt_pkg::DATA_W-1:0]     rad;
  logic [divsqrt_pkg::SQRT_STEPS-1:0] root;

  // Signed partial remainder, sign in the top bit
  logic [divsqrt_pkg::SQRT_STEPS+2:0] prem;
  logic [divsqrt_pkg::SQRT_STEPS+2:0] prem_shift;
  logic [divsqrt_pkg::SQRT_STEPS+2:0] prem_next;

  // ##########################################################################
  // Control FSM
  // ##########################################################################

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_IDLE;
      step  <= '0;
    end else begin
      case (state)
        S_IDLE: if (new_request) state <= S_LOAD;
        S_LOAD: begin
          state <= S_STEP;
          step  <= '0;
        end
        S_STEP: begin
          step <= step + 1'b1;
          if (step == divsqrt_pkg::SQRT_STEPS - 1)
            state <= S_RESULT;
        end
        S_RESULT: state <= S_DONE;
        S_DONE: if (ack) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  assign ready = (state == S_IDLE);
  assign done  = (state == S_DONE);

  // ##########################################################################
  // Non-restoring digit recurrence
  // ##########################################################################

  // Bring down the next two radicand bits
  assign prem_shift = {prem[divsqrt_pkg::SQRT_STEPS:0], rad[divsqrt_pkg::DATA_W-1 -: 2]};

  always_comb begin
    if (prem[divsqrt_pkg::SQRT_STEPS+2])
      prem_next = prem_shift + {1'b0, root, 2'b11};
    else
      prem_next = prem_shift - {1'b0, root, 2'b01};
  end

  always_ff @(posedge clk) begin
    case (state)
      S_IDLE: begin
        if (new_request) begin
          rad     <= rs1;
          done_id <= id;
        end
      end
      S_LOAD: begin
        prem <= '0;
        root <= '0;
      end
      S_STEP: begin
        prem <= prem_next;
        rad  <= {rad[divsqrt_pkg::DATA_W-3:0], 2'b00};
        // Root bit set when the new remainder stays non-negative
        root <= {root[divsqrt_pkg::SQRT_STEPS-2:0], ~prem_next[divsqrt_pkg::SQRT_STEPS+2]};
      end
      S_RESULT: result <= {{(divsqrt_pkg::DATA_W-divsqrt_pkg::SQRT_STEPS){1'b0}}, root};
      default: ;
    endcase
  end

endmodule

// ==== div_sqrt_unit.sv ====
`timescale 1ns/100ps

module div_sqrt_unit (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           new_request,
  input  logic [divsqrt_pkg::ID_W-1:0]   id,
  input  divsqrt_pkg::op_t               op,
  input  logic [divsqrt_pkg::DATA_W-1:0] rs1,
  input  logic [divsqrt_pkg::DATA_W-1:0] rs2,
  input  logic                           wb_ack,
  output logic                           ready,
  output logic                           wb_done,
  output logic [divsqrt_pkg::ID_W-1:0]   wb_id,
  output logic [divsqrt_pkg::DATA_W-1:0] wb_rd,
  output logic                           wb_dz
);

  logic                           is_div;

  logic                           div_request;
  logic                           div_ready;
  logic                           div_done;
  logic                           div_ack;
  logic [divsqrt_pkg::ID_W-1:0]   div_id;
  logic [divsqrt_pkg::DATA_W-1:0] div_rd;
  logic                           div_dz;

  logic                           sqrt_request;
  logic                           sqrt_ready;
  logic                           sqrt_done;
  logic                           sqrt_ack;
  logic [divsqrt_pkg::ID_W-1:0]   sqrt_id;
  logic [divsqrt_pkg::DATA_W-1:0] sqrt_rd;

  // ##########################################################################
  // Issue steering
  // ##########################################################################

  assign is_div = (op == divsqrt_pkg::OP_DIV) || (op == divsqrt_pkg::OP_REM);

  // Requests pass only while both units are idle
  assign div_request  = new_request & ready & is_div;
  assign sqrt_request = new_request & ready & ~is_div;

  // One operation in flight across both units
  assign ready = div_ready & sqrt_ready;

  int_div div (
    .clk         (clk),
    .rst_n       (rst_n),
    .new_request (div_request),
    .id          (id),
    .op          (op),
    .rs1         (rs1),
    .rs2         (rs2),
    .ack         (div_ack),
    .ready       (div_ready),
    .done        (div_done),
    .done_id     (div_id),
    .result      (div_rd),
    .dz          (div_dz)
  );

  int_sqrt sqrt (
    .clk         (clk),
    .rst_n       (rst_n),
    .new_request (sqrt_request),
    .id          (id),
    .rs1         (rs1),
    .ack         (sqrt_ack),
    .ready       (sqrt_ready),
    .done        (sqrt_done),
    .done_id     (sqrt_id),
    .result      (sqrt_rd)
  );

  // ##########################################################################
  // Write-back merge with divider priority
  // ##########################################################################

  always_comb begin
    div_ack  = wb_ack & div_done;
    sqrt_ack = wb_ack & sqrt_done;
    if (div_done) begin
      wb_done = div_done;
      wb_id   = div_id;
      wb_rd   = div_rd;
      wb_dz   = div_dz;
    end else begin
      wb_done = sqrt_done;
      wb_id   = sqrt_id;
      wb_rd   = sqrt_rd;
      wb_dz   = 1'b0;
    end
  end

endmodule

// ==== div_sqrt_checker.sv ====
`timescale 1ns/100ps

module div_sqrt_checker (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           new_request,
  input logic                           ready,
  input logic                           wb_done,
  input logic [divsqrt_pkg::ID_W-1:0]   wb_id,
  input logic [divsqrt_pkg::DATA_W-1:0] wb_rd,
  input logic                           wb_dz,
  input logic                           wb_ack
);

  // Result held until the ack edge
  held_result: assert property (@(posedge clk) disable iff (!rst_n)
    wb_done && !wb_ack |=> wb_done && $stable(wb_id) && $stable(wb_rd) && $stable(wb_dz))
    else $error("write-back changed while waiting for ack");

  busy_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
    new_request && ready |=> !ready)
    else $error("ready still high in the cycle after an accepted request");

  ready_vs_done: assert property (@(posedge clk) disable iff (!rst_n)
    !(ready && wb_done))
    else $error("ready and wb_done high together");

  // Idle state follows every reset cycle
  reset_state: assert property (@(posedge clk) !rst_n |=> !wb_done && ready)
    else $error("unit not idle after reset");

endmodule

bind div_sqrt_unit div_sqrt_checker u_checker (
  .clk         (clk),
  .rst_n       (rst_n),
  .new_request (new_request),
  .ready       (ready),
  .wb_done     (wb_done),
  .wb_id       (wb_id),
  .wb_rd       (wb_rd),
  .wb_dz       (wb_dz),
  .wb_ack      (wb_ack)
);

// ==== div_sqrt_monitor.sv ====
`timescale 1ns/100ps

module div_sqrt_monitor (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           new_request,
  input  logic [divsqrt_pkg::ID_W-1:0]   id,
  input  divsqrt_pkg::op_t               op,
  input  logic [divsqrt_pkg::DATA_W-1:0] rs1,
  input  logic [divsqrt_pkg::DATA_W-1:0] rs2,
  input  logic                           ready,
  input  logic                           wb_done,
  input  logic [divsqrt_pkg::ID_W-1:0]   wb_id,
  input  logic [divsqrt_pkg::DATA_W-1:0] wb_rd,
  input  logic                           wb_dz,
  input  logic                           wb_ack,
  output int                             completed,
  output int                             errors,
  output int                             pending
);

  logic [divsqrt_pkg::ID_W-1:0]   q_id[$];
  logic [1:0]                     q_op[$];
  logic [divsqrt_pkg::DATA_W-1:0] q_rs1[$];
  logic [divsqrt_pkg::DATA_W-1:0] q_rs2[$];
  int                             q_cyc[$];

  int          cyc = 0;
  int          lat;
  int          exp_lat;
  logic        prev_done;
  logic        ready_due;
  logic        bad;
  logic [32:0] expected;

  // {dz, rd} for one request
  function automatic logic [32:0] reference_result(input logic [1:0] op_bits,
                                                   input logic [31:0] a,
                                                   input logic [31:0] b);
    logic [63:0] root;
    root = '0;
    if (op_bits == divsqrt_pkg::OP_DIV)
      return (b == 0) ? {1'b1, 32'hffff_ffff} : {1'b0, a / b};
    if (op_bits == divsqrt_pkg::OP_REM)
      return (b == 0) ? {1'b1, a} : {1'b0, a % b};
    while ((root + 1) * (root + 1) <= {32'h0, a})
      root = root + 1;
    return {1'b0, root[31:0]};
  endfunction

  // ##########################################################################
  // Sampled on the rising edge, before the DUT registers update
  // ##########################################################################

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (!rst_n) begin
      completed = 0;
      errors    = 0;
      prev_done = 1'b0;
      ready_due = 1'b0;
      q_id.delete();
      q_op.delete();
      q_rs1.delete();
      q_rs2.delete();
      q_cyc.delete();
    end else begin
      if (ready_due && !ready) begin
        $display("Ready did not return in the cycle after the ack");
        errors++;
      end
      ready_due = 1'b0;
      if (wb_done && ready) begin
        $display("Ready was high while a result was held");
        errors++;
      end
      if (wb_done && !prev_done) begin
        if (q_id.size() == 0) begin
          $display("A write-back appeared with no outstanding request");
          errors++;
        end else begin
          exp_lat = (q_op[0] == divsqrt_pkg::OP_DIV || q_op[0] == divsqrt_pkg::OP_REM) ?
                    divsqrt_pkg::DIV_LATENCY : divsqrt_pkg::SQRT_LATENCY;
          lat = cyc - q_cyc[0] - 1;
          if (lat != exp_lat) begin
            $display("Fail wb_done latency expected %h got %h", exp_lat, lat);
            errors++;
          end
        end
      end
      if (wb_done && wb_ack && q_id.size() != 0) begin
        expected = reference_result(q_op[0], q_rs1[0], q_rs2[0]);
        bad = 1'b0;
        if (wb_id !== q_id[0]) begin
          $display("Fail wb_id expected %h got %h", q_id[0], wb_id);
          bad = 1'b1;
        end
        if (wb_rd !== expected[31:0]) begin
          $display("Fail wb_rd expected %h got %h", expected[31:0], wb_rd);
          bad = 1'b1;
        end
        if (wb_dz !== expected[32]) begin
          $display("Fail wb_dz expected %h got %h", expected[32], wb_dz);
          bad = 1'b1;
        end
        if (bad)
          errors++;
        $display("Test %0d id %0d op %0d rs1 %h rs2 %h rd %h: %s", completed, q_id[0],
                 q_op[0], q_rs1[0], q_rs2[0], wb_rd, bad ? "mismatch" : "ok");
        completed++;
        q_id.pop_front();
        q_op.pop_front();
        q_rs1.pop_front();
        q_rs2.pop_front();
        q_cyc.pop_front();
        ready_due = 1'b1;
      end
      if (new_request && ready) begin
        q_id.push_back(id);
        q_op.push_back(op);
        q_rs1.push_back(rs1);
        q_rs2.push_back(rs2);
        q_cyc.push_back(cyc);
      end
      prev_done = wb_done;
    end
    pending = q_id.size();
  end

endmodule

// ==== tb_div_sqrt.sv ====
`timescale 1ns/100ps

module tb_div_sqrt;

  localparam int          NUM_TESTS     = 200;
  localparam int          RESET_CYCLES  = 16;
  localparam int          MAX_ACK_DELAY = 3;
  localparam logic [15:0] LFSR_SEED     = 16'd15920;
  localparam int          TIMEOUT_CYCLES =
    NUM_TESTS * (divsqrt_pkg::DIV_LATENCY + MAX_ACK_DELAY + 4) + RESET_CYCLES;

  logic                           clk;
  logic                           rst_n;
  logic                           new_request;
  logic [divsqrt_pkg::ID_W-1:0]   id;
  divsqrt_pkg::op_t               op;
  logic [divsqrt_pkg::DATA_W-1:0] rs1;
  logic [divsqrt_pkg::DATA_W-1:0] rs2;
  logic                           wb_ack;
  logic                           ready;
  logic                           wb_done;
  logic [divsqrt_pkg::ID_W-1:0]   wb_id;
  logic [divsqrt_pkg::DATA_W-1:0] wb_rd;
  logic                           wb_dz;

  int                           completed;
  int                           errors;
  int                           pending;
  int                           cycles;
  int                           test_idx;
  int                           delay;
  logic [15:0]                  lfsr;
  logic [31:0]                  draw;
  logic [31:0]                  a;
  logic [31:0]                  b;
  logic [1:0]                   op_bits;
  logic [divsqrt_pkg::ID_W-1:0] next_id;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  div_sqrt_unit u_div_sqrt_unit (.*);

  div_sqrt_monitor u_monitor (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d tests completed", cycles, completed);
    $display("Testbench failed");
    $finish;
  end

  // ##########################################################################
  // Stimulus driven on the falling edge
  // ##########################################################################

  initial begin
    rst_n       = 1'b0;
    new_request = 1'b0;
    id          = '0;
    op          = divsqrt_pkg::OP_DIV;
    rs1         = '0;
    rs2         = '0;
    wb_ack      = 1'b0;
    lfsr        = LFSR_SEED;
    next_id     = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    for (test_idx = 0; test_idx < NUM_TESTS; test_idx++) begin
      draw    = take_bits(2);
      op_bits = draw[1:0];
      a       = take_bits(32);
      b       = take_bits(32);
      if (take_bits(3) == 0) begin
        a = a & 32'h0000_00ff;
        b = b & 32'h0000_000f;
      end
      if (take_bits(3) == 0)
        b = '0;
      delay = take_bits(2) % (MAX_ACK_DELAY + 1);
      // Edge cases first
      case (test_idx)
        0: begin
          op_bits = 2'b10;
          a       = 32'h0;
        end
        1: begin
          op_bits = 2'b10;
          a       = 32'hffff_ffff;
        end
        2: begin
          op_bits = 2'b10;
          a       = 32'd1522756;
        end
        3: begin
          op_bits = 2'b00;
          b       = '0;
        end
        4: begin
          op_bits = 2'b01;
          b       = '0;
        end
        default: ;
      endcase
      while (!ready) @(negedge clk);
      new_request = 1'b1;
      id          = next_id;
      op          = divsqrt_pkg::op_t'(op_bits);
      rs1         = a;
      rs2         = b;
      @(negedge clk);
      // Stray request to the other unit while busy must be ignored
      op = op_bits[1] ? divsqrt_pkg::OP_DIV : divsqrt_pkg::OP_SQRT;
      @(negedge clk);
      new_request = 1'b0;
      next_id     = next_id + 1'b1;
      while (!wb_done) @(negedge clk);
      repeat (delay) @(negedge clk);
      wb_ack = 1'b1;
      @(negedge clk);
      wb_ack = 1'b0;
    end
    repeat (2) @(negedge clk);
    $display("Summary: %0d of %0d tests completed, %0d errors, %0d outstanding",
             completed, NUM_TESTS, errors, pending);
    if (errors == 0 && completed == NUM_TESTS && pending == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
divsqrt_pkg.sv
int_div.sv
int_sqrt.sv
div_sqrt_unit.sv
div_sqrt_checker.sv
div_sqrt_monitor.sv
tb_div_sqrt.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the divide and square-root testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_div_sqrt \
  -f verilog.f -o Vtb_div_sqrt > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_div_sqrt > sim.log 2>&1 || echo "Testbench failed" >> sim.log
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0
